/* all.f */
hdl/rmii_pkg.sv
hdl/sync_fifo.sv
hdl/rmii_byte_packager.sv
hdl/frame_check_sequence_generator.sv
hdl/ethernet_packet_parser.sv
hdl/receive_slot_handler.sv
hdl/rmii_port.sv
verification/rmii_port_sva.sv
verification/rmii_port_tb.sv

/* hdl/ethernet_packet_parser.sv */
module ethernet_packet_parser import rmii_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  rx_byte_t      frame_data,
    input  logic          frame_valid,
    output logic          frame_read,
    input  logic          frame_empty,
    input  logic          slot_free,
    output payload_byte_t payload_data,
    output logic          payload_write,
    output logic [7:0]    crc_data,
    output logic          crc_valid,
    output logic          crc_last,
    input  crc_t          crc_result,
    input  logic          crc_result_valid,
    output logic          good_packet,
    output logic          bad_packet
);

    typedef enum logic [1:0] {HUNT, PAYLOAD, SKIP, VERDICT} state_t;

    state_t                               state;
    logic [$clog2(MAX_FRAME_BYTES + 1):0] frame_length;
    logic                                 error_seen;
    logic                                 in_payload;
    logic                                 length_ok;
    logic                                 frame_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Frame FIFO pops, one byte in flight at a time
    ////////////////////////////////////////////////////////////////////////////

    assign frame_read = !frame_empty && !frame_valid &&
                        ((state == HUNT && slot_free) || state == PAYLOAD || state == SKIP);

    assign in_payload = (state == PAYLOAD) && frame_valid;

    assign crc_data      = frame_data.data;
    assign crc_valid     = in_payload;
    assign crc_last      = frame_data.last;
    assign payload_data  = '{last: frame_data.last, data: frame_data.data};
    assign payload_write = in_payload && (frame_length < MAX_FRAME_BYTES);

    ////////////////////////////////////////////////////////////////////////////
    // Verdict
    ////////////////////////////////////////////////////////////////////////////

    assign length_ok = (frame_length >= MIN_FRAME_BYTES) && (frame_length <= MAX_FRAME_BYTES);
    assign frame_ok  = (crc_result == CRC_RESIDUE) && !error_seen && length_ok;

    assign good_packet = (state == VERDICT) && crc_result_valid && frame_ok;
    assign bad_packet  = (state == VERDICT) && crc_result_valid && !frame_ok;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= HUNT;
        end else begin
            case (state)
                HUNT: begin
                    // A burst that ends here has nothing left to skip
                    if (frame_valid && !frame_data.last) begin
                        if (frame_data.data == SFD_BYTE) begin
                            state <= PAYLOAD;
                        end else if (frame_data.data != PREAMBLE_BYTE) begin
                            state <= SKIP;
                        end
                    end
                end
                PAYLOAD: begin
                    if (frame_valid && frame_data.last) begin
                        state <= VERDICT;
                    end
                end
                SKIP: begin
                    if (frame_valid && frame_data.last) begin
                        state <= HUNT;
                    end
                end
                VERDICT: begin
                    if (crc_result_valid) begin
                        state <= HUNT;
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

    // Length keeps counting past the write limit, saturating at the top
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_length <= '0;
            error_seen   <= 1'b0;
        end else if (state == HUNT) begin
            frame_length <= '0;
            error_seen   <= 1'b0;
        end else if (in_payload) begin
            if (frame_length != '1) begin
                frame_length <= frame_length + 1'b1;
            end
            error_seen <= error_seen | frame_data.error;
        end
    end

endmodule

/* hdl/frame_check_sequence_generator.sv */
module frame_check_sequence_generator import rmii_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] crc_data,
    input  logic       crc_valid,
    input  logic       crc_last,
    output crc_t       crc_result,
    output logic       crc_result_valid
);

    crc_t crc_register;
    crc_t crc_next;

    // One byte through the reflected polynomial, LSB first
    function automatic crc_t crc_update(crc_t crc, logic [7:0] data);
        crc_t c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_update(crc_register, crc_data);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc_register     <= CRC_INIT;
            crc_result_valid <= 1'b0;
        end else begin
            crc_result_valid <= crc_valid && crc_last;
            if (crc_valid) begin
                // Start over for the next frame
                crc_register <= crc_last ? CRC_INIT : crc_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (crc_valid && crc_last) begin
            crc_result <= crc_next;
        end
    end

endmodule

/* hdl/receive_slot_handler.sv */
module receive_slot_handler import rmii_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          good_packet,
    input  logic          bad_packet,
    input  payload_byte_t fifo_data,
    input  logic          fifo_valid,
    input  logic          fifo_empty,
    output logic          fifo_read,
    output logic          fifo_reset_n,
    output logic          slot_free,
    output payload_byte_t receive_data,
    output logic          receive_valid,
    input  logic          receive_ready
);

    typedef enum logic {IDLE, DRAIN} state_t;

    state_t        state;
    payload_byte_t hold_data;
    logic          hold_valid;
    logic          take;

    assign take = hold_valid && receive_ready;

    // Pop only when the holding register has room by the time data lands
    assign fifo_read = (state == DRAIN) && !fifo_empty && !fifo_valid &&
                       (!hold_valid || receive_ready);

    // Flush still pending keeps the slot busy
    assign slot_free = (state == IDLE) && fifo_empty && fifo_reset_n;

    assign receive_data  = hold_data;
    assign receive_valid = hold_valid;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= IDLE;
            hold_valid   <= 1'b0;
            fifo_reset_n <= 1'b1;
        end else begin
            fifo_reset_n <= !bad_packet;
            if (fifo_valid) begin
                hold_valid <= 1'b1;
            end else if (take) begin
                hold_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (good_packet) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (take && hold_data.last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_valid) begin
            hold_data <= fifo_data;
        end
    end

endmodule

/* hdl/rmii_byte_packager.sv */
module rmii_byte_packager import rmii_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  dibit_t   rmii_receive_data,
    input  logic     rmii_receive_data_enable,
    input  logic     rmii_receive_data_error,
    output rx_byte_t packaged_data,
    output logic     packaged_valid
);

    logic [7:0] shift_data;
    logic [1:0] dibit_count;
    logic       error_seen;
    logic [7:0] hold_data;
    logic       hold_error;
    logic       hold_valid;
    logic       partial_end;

    // Burst stopped in the middle of a byte
    assign partial_end = !rmii_receive_data_enable && (dibit_count != 2'd0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dibit_count <= 2'd0;
            error_seen  <= 1'b0;
            hold_valid  <= 1'b0;
        end else if (rmii_receive_data_enable) begin
            dibit_count <= dibit_count + 2'd1;
            hold_valid  <= (dibit_count == 2'd3);
            if (dibit_count == 2'd3) begin
                error_seen <= 1'b0;
            end else begin
                error_seen <= error_seen | rmii_receive_data_error;
            end
        end else begin
            dibit_count <= 2'd0;
            error_seen  <= 1'b0;
            hold_valid  <= 1'b0;
        end
    end

    // Least significant dibit arrives first
    always_ff @(posedge clock) begin
        if (rmii_receive_data_enable) begin
            shift_data <= {rmii_receive_data, shift_data[7:2]};
            if (dibit_count == 2'd3) begin
                hold_data  <= {rmii_receive_data, shift_data[7:2]};
                hold_error <= error_seen | rmii_receive_data_error;
            end
        end
    end

    // Enable seen one dibit after completion decides the last flag
    always_comb begin
        packaged_valid = hold_valid | partial_end;
        if (hold_valid) begin
            packaged_data.last  = !rmii_receive_data_enable;
            packaged_data.error = hold_error;
            packaged_data.data  = hold_data;
        end else begin
            packaged_data.last  = 1'b1;
            packaged_data.error = 1'b1;
            packaged_data.data  = shift_data;
        end
    end

endmodule

/* hdl/rmii_pkg.sv */
package rmii_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Byte and register types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [1:0] dibit_t;

    // Byte as assembled from the RMII pins
    typedef struct packed {
        logic       last;
        logic       error;
        logic [7:0] data;
    } rx_byte_t;

    // Byte held in the receive slot and sent to the core
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } payload_byte_t;

    typedef logic [31:0] crc_t;

    ////////////////////////////////////////////////////////////////////////////
    // Frame constants
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // Reflected Ethernet CRC-32, no final inversion applied in hardware
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

    // Counted after the delimiter, FCS included
    localparam int MIN_FRAME_BYTES = 64;
    localparam int MAX_FRAME_BYTES = 1522;

    localparam int FRAME_FIFO_DEPTH   = 2048;
    localparam int PAYLOAD_FIFO_DEPTH = 2048;

endpackage

/* hdl/rmii_port.sv */
module rmii_port import rmii_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  dibit_t        rmii_receive_data,
    input  logic          rmii_receive_data_enable,
    input  logic          rmii_receive_data_error,
    output payload_byte_t receive_data,
    output logic          receive_valid,
    input  logic          receive_ready
);

    rx_byte_t      packaged_data;
    logic          packaged_valid;
    rx_byte_t      frame_read_data;
    logic          frame_read_data_valid;
    logic          frame_read;
    logic          frame_full;
    logic          frame_empty;
    logic [7:0]    crc_data;
    logic          crc_valid;
    logic          crc_last;
    crc_t          crc_result;
    logic          crc_result_valid;
    payload_byte_t payload_write_data;
    logic          payload_write;
    payload_byte_t payload_read_data;
    logic          payload_read_data_valid;
    logic          payload_read;
    logic          payload_empty;
    logic          good_packet;
    logic          bad_packet;
    logic          slot_free;
    logic          fifo_reset_n;
    logic          payload_fifo_rst_n;

    // Slot discard reuses the payload FIFO reset
    assign payload_fifo_rst_n = rst_n & fifo_reset_n;

    ////////////////////////////////////////////////////////////////////////////
    // Pins to frame FIFO
    ////////////////////////////////////////////////////////////////////////////

    rmii_byte_packager rmii_byte_packager (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .packaged_data            (packaged_data),
        .packaged_valid           (packaged_valid)
    );

    sync_fifo #(
        .entry_t (rx_byte_t),
        .DEPTH   (FRAME_FIFO_DEPTH)
    ) frame_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .write_enable    (packaged_valid),
        .write_data      (packaged_data),
        .read_enable     (frame_read),
        .read_data       (frame_read_data),
        .read_data_valid (frame_read_data_valid),
        .full            (frame_full),
        .empty           (frame_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Parsing and CRC check
    ////////////////////////////////////////////////////////////////////////////

    ethernet_packet_parser ethernet_packet_parser (
        .clock            (clock),
        .rst_n            (rst_n),
        .frame_data       (frame_read_data),
        .frame_valid      (frame_read_data_valid),
        .frame_read       (frame_read),
        .frame_empty      (frame_empty),
        .slot_free        (slot_free),
        .payload_data     (payload_write_data),
        .payload_write    (payload_write),
        .crc_data         (crc_data),
        .crc_valid        (crc_valid),
        .crc_last         (crc_last),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid),
        .good_packet      (good_packet),
        .bad_packet       (bad_packet)
    );

    frame_check_sequence_generator frame_check_sequence_generator (
        .clock            (clock),
        .rst_n            (rst_n),
        .crc_data         (crc_data),
        .crc_valid        (crc_valid),
        .crc_last         (crc_last),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Receive slot
    ////////////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .entry_t (payload_byte_t),
        .DEPTH   (PAYLOAD_FIFO_DEPTH)
    ) payload_fifo (
        .clock           (clock),
        .rst_n           (payload_fifo_rst_n),
        .write_enable    (payload_write),
        .write_data      (payload_write_data),
        .read_enable     (payload_read),
        .read_data       (payload_read_data),
        .read_data_valid (payload_read_data_valid),
        .full            (),
        .empty           (payload_empty)
    );

    receive_slot_handler receive_slot_handler (
        .clock         (clock),
        .rst_n         (rst_n),
        .good_packet   (good_packet),
        .bad_packet    (bad_packet),
        .fifo_data     (payload_read_data),
        .fifo_valid    (payload_read_data_valid),
        .fifo_empty    (payload_empty),
        .fifo_read     (payload_read),
        .fifo_reset_n  (fifo_reset_n),
        .slot_free     (slot_free),
        .receive_data  (receive_data),
        .receive_valid (receive_valid),
        .receive_ready (receive_ready)
    );

endmodule

/* hdl/sync_fifo.sv */
module sync_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   write_enable,
    input  entry_t write_data,
    input  logic   read_enable,
    output entry_t read_data,
    output logic   read_data_valid,
    output logic   full,
    output logic   empty
);

    entry_t                       memory [DEPTH];
    logic [$clog2(DEPTH)-1:0]     write_pointer;
    logic [$clog2(DEPTH)-1:0]     read_pointer;
    logic [$clog2(DEPTH + 1)-1:0] count;
    logic                         do_write;
    logic                         do_read;

    assign full     = (count == DEPTH);
    assign empty    = (count == 0);
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            count           <= '0;
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= do_read;
            if (do_write) begin
                write_pointer <= (write_pointer == DEPTH - 1) ? '0 : write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= (read_pointer == DEPTH - 1) ? '0 : read_pointer + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
        if (do_read) begin
            read_data <= memory[read_pointer];
        end
    end

endmodule

/* verification/rmii_port_sva.sv */
module rmii_port_sva import rmii_pkg::*; (
    input logic          clock,
    input logic          rst_n,
    input payload_byte_t receive_data,
    input logic          receive_valid,
    input logic          receive_ready,
    input logic          frame_write,
    input logic          frame_full,
    input logic          good_packet,
    input logic          bad_packet
);

    timeunit 1ns;
    timeprecision 1ps;

    int failure_count = 0;

    // Output held while the core stalls
    hold_while_stalled: assert property (@(posedge clock) disable iff (!rst_n)
        receive_valid && !receive_ready |=> $stable(receive_data))
    else begin
        $error("receive_data changed while receive_ready was low");
        failure_count++;
    end

    no_frame_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        !(frame_write && frame_full))
    else begin
        $error("frame FIFO written while full");
        failure_count++;
    end

    single_verdict: assert property (@(posedge clock) disable iff (!rst_n)
        !(good_packet && bad_packet))
    else begin
        $error("good_packet and bad_packet high together");
        failure_count++;
    end

    quiet_after_reset: assert property (@(posedge clock) !rst_n |=> !receive_valid)
    else begin
        $error("receive_valid high in the cycle after reset");
        failure_count++;
    end

endmodule

bind rmii_port rmii_port_sva sva0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .receive_data  (receive_data),
    .receive_valid (receive_valid),
    .receive_ready (receive_ready),
    .frame_write   (packaged_valid),
    .frame_full    (frame_full),
    .good_packet   (good_packet),
    .bad_packet    (bad_packet)
);

/* verification/rmii_port_tb.sv */
module rmii_port_tb import rmii_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED          = 32'h6742_2a8e;
    localparam int          CLOCK_HALF    = 50;
    localparam int          FRAME_COUNT   = 24;
    localparam int          DRAIN_TIMEOUT = 40000;
    localparam int          IDLE_BYTES    = 12;

    localparam int KIND_GOOD     = 0;
    localparam int KIND_CORRUPT  = 1;
    localparam int KIND_RX_ERROR = 2;
    localparam int KIND_SHORT    = 3;

    typedef logic [7:0] byte_q_t[$];

    logic          clock = 1'b0;
    logic          rst_n;
    dibit_t        rmii_receive_data;
    logic          rmii_receive_data_enable;
    logic          rmii_receive_data_error;
    payload_byte_t receive_data;
    logic          receive_valid;
    logic          receive_ready;

    payload_byte_t expected_q[$];
    int            expected_frames  = 0;
    int            delivered_frames = 0;
    logic [31:0]   frame_rng        = SEED;
    logic [31:0]   ready_rng        = SEED;

    rmii_port dut0 (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data             (receive_data),
        .receive_valid            (receive_valid),
        .receive_ready            (receive_ready)
    );

    always #CLOCK_HALF clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int limit);
        frame_rng = lcg_next(frame_rng);
        return int'(frame_rng[31:8]) % limit;
    endfunction

    // Bit-serial CRC-32 with final inversion
    function automatic logic [31:0] crc32(input byte_q_t frame_bytes);
        logic [31:0] crc;
        logic        feedback;
        crc = CRC_INIT;
        foreach (frame_bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ frame_bytes[i][b];
                crc = crc >> 1;
                if (feedback) begin
                    crc = crc ^ CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic int data_length_for(input int kind);
        if (kind == KIND_SHORT) begin
            return 20 + rand_below(36);
        end
        return 60 + rand_below(120);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_payload(input payload_byte_t expected, input payload_byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch receive_data: expected %h, got %h", expected, actual));
        end
    endtask

    task automatic compare_count(input int expected, input int actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch delivered_frames: expected %h, got %h",
                                expected, actual));
        end
    endtask

    task automatic wait_for_delivery(input string what);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort_run($sformatf("timed out waiting for good frames after %s", what));
            end
        end
        compare_count(expected_frames, delivered_frames);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Preamble, delimiter, payload, then the interframe gap
    task automatic send_frame(input byte_q_t payload, input int error_index,
                              input int error_dibit);
        byte_q_t stream;
        stream = {};
        repeat (7) stream.push_back(PREAMBLE_BYTE);
        stream.push_back(SFD_BYTE);
        foreach (payload[i]) stream.push_back(payload[i]);
        for (int i = 0; i < stream.size(); i++) begin
            for (int d = 0; d < 4; d++) begin
                @(posedge clock);
                rmii_receive_data        <= stream[i][2*d +: 2];
                rmii_receive_data_enable <= 1'b1;
                rmii_receive_data_error  <= (error_index >= 0) &&
                                            (i == error_index + 8) && (d == error_dibit);
            end
        end
        @(posedge clock);
        rmii_receive_data        <= 2'b00;
        rmii_receive_data_enable <= 1'b0;
        rmii_receive_data_error  <= 1'b0;
        repeat (IDLE_BYTES * 4 - 1) @(posedge clock);
    endtask

    task automatic run_frame(input int kind, input int data_length);
        byte_q_t       payload;
        logic [31:0]   fcs;
        payload_byte_t entry;
        int            total;
        int            corrupt_index;
        int            error_index;
        int            error_dibit;
        bit            good;
        payload = {};
        for (int i = 0; i < data_length; i++) begin
            payload.push_back(8'(rand_below(256)));
        end
        fcs = crc32(payload);
        for (int i = 0; i < 4; i++) begin
            payload.push_back(fcs[8*i +: 8]);
        end
        total = payload.size();
        good  = (kind != KIND_CORRUPT) && (kind != KIND_RX_ERROR) &&
                (total >= MIN_FRAME_BYTES) && (total <= MAX_FRAME_BYTES);
        error_index = -1;
        error_dibit = 0;
        if (kind == KIND_CORRUPT) begin
            corrupt_index = rand_below(total);
            payload[corrupt_index] = payload[corrupt_index] ^ 8'(1 + rand_below(255));
        end
        if (kind == KIND_RX_ERROR) begin
            error_index = rand_below(total);
            error_dibit = rand_below(4);
        end
        if (good) begin
            foreach (payload[i]) begin
                entry.last = (i == total - 1);
                entry.data = payload[i];
                expected_q.push_back(entry);
            end
            expected_frames++;
        end
        send_frame(payload, error_index, error_dibit);
    endtask

    // Ready at least every other cycle
    always @(posedge clock) begin
        ready_rng = lcg_next(ready_rng);
        if (!receive_ready) begin
            receive_ready <= 1'b1;
        end else begin
            receive_ready <= ready_rng[31];
        end
    end

    // Scoreboard on accepted output bytes
    always @(posedge clock) begin
        payload_byte_t expected;
        if (rst_n && receive_valid && expected_q.size() == 0) begin
            abort_run("receive_valid went high with no good frame pending");
        end else if (rst_n && receive_valid && receive_ready) begin
            expected = expected_q.pop_front();
            compare_payload(expected, receive_data);
            if (receive_data.last) begin
                delivered_frames++;
            end
        end
    end

    initial begin
        int kind;
        rst_n                    = 1'b0;
        rmii_receive_data        = 2'b00;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        receive_ready            = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // Nothing comes out for a dropped frame
        run_frame(KIND_CORRUPT, 70);
        wait_for_delivery("first dropped frame");

        run_frame(KIND_GOOD, data_length_for(KIND_GOOD));
        wait_for_delivery("single good frame");

        run_frame(KIND_CORRUPT, data_length_for(KIND_CORRUPT));
        run_frame(KIND_GOOD, data_length_for(KIND_GOOD));
        wait_for_delivery("corrupted frame");

        run_frame(KIND_RX_ERROR, data_length_for(KIND_RX_ERROR));
        run_frame(KIND_GOOD, data_length_for(KIND_GOOD));
        wait_for_delivery("receive error frame");

        run_frame(KIND_SHORT, data_length_for(KIND_SHORT));
        run_frame(KIND_GOOD, data_length_for(KIND_GOOD));
        wait_for_delivery("short frame");

        // Mixed traffic, about half good
        for (int i = 0; i < FRAME_COUNT; i++) begin
            kind = rand_below(7);
            kind = (kind < 4) ? KIND_GOOD : kind - 3;
            run_frame(kind, data_length_for(kind));
        end
        wait_for_delivery("mixed sequence");

        if (dut0.sva0.failure_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("bound assertions flagged a protocol violation");
        end
    end

endmodule
